/* hist_builder.sv */
`timescale 1ns/1ps

module hist_builder (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         acc,
    input  logic [sifh_pkg::NB-1:0]      addr,
    input  logic [sifh_pkg::PIX_W-1:0]   pixel,
    input  logic                         clear_start,
    output logic                         clear_done,
    output logic                         hit,
    output logic [sifh_pkg::NB-1:0]      hit_bin,
    output logic [sifh_pkg::COUNT_W-1:0] hit_count
);

    logic [sifh_pkg::COUNT_W-1:0] mem [sifh_pkg::MEM_DEPTH];
    // pass that last wrote each bin, so the fine pass starts from zero
    sifh_pkg::hist_sel_e          tag [sifh_pkg::MEM_DEPTH];

    logic                         sweeping;
    logic [sifh_pkg::ADDR_W-1:0]  sweep_addr;
    logic [sifh_pkg::ADDR_W-1:0]  idx;
    sifh_pkg::hist_sel_e          pass;
    sifh_pkg::hist_sel_e          cur_sel;
    logic [sifh_pkg::PIX_W-1:0]   prev_pixel;
    logic [sifh_pkg::COUNT_W-1:0] old_count;
    logic [sifh_pkg::COUNT_W-1:0] inc_count;

    assign idx        = {pixel, addr};
    // pixel index wrapping back means the fine pass has begun
    assign cur_sel    = (pass == sifh_pkg::FINE || pixel < prev_pixel) ?
                        sifh_pkg::FINE : sifh_pkg::COARSE;
    assign old_count  = (tag[idx] == cur_sel) ? mem[idx] : '0;
    assign inc_count  = old_count + 1'b1;
    assign clear_done = sweeping && (sweep_addr == sifh_pkg::MEM_DEPTH - 1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sweeping   <= 1'b0;
            sweep_addr <= '0;
            pass       <= sifh_pkg::COARSE;
            prev_pixel <= '0;
            hit        <= 1'b0;
        end else begin
            hit <= acc;
            if (clear_start) begin
                sweeping   <= 1'b1;
                sweep_addr <= '0;
                pass       <= sifh_pkg::COARSE;
                prev_pixel <= '0;
            end else if (sweeping) begin
                sweep_addr <= sweep_addr + 1'b1;
                if (clear_done) begin
                    sweeping <= 1'b0;
                end
            end else if (acc) begin
                pass       <= cur_sel;
                prev_pixel <= pixel;
            end
        end
    end

    // read-modify-write in one cycle, sweep has priority
    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweep_addr] <= '0;
            tag[sweep_addr] <= sifh_pkg::COARSE;
        end else if (acc) begin
            mem[idx] <= inc_count;
            tag[idx] <= cur_sel;
        end
        hit_bin   <= addr;
        hit_count <= inc_count;
    end

    a_no_acc_in_sweep: assert property (@(posedge clk) disable iff (!res)
        sweeping |-> !acc);

endmodule

/* list.f */
sifh_pkg.sv
sifh_fsm.sv
hist_builder.sv
peak_tracker.sv
peak_combiner.sv
sifh_top.sv
tb_sifh.sv

/* peak_combiner.sv */
`timescale 1ns/1ps

module peak_combiner (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       peak_valid,
    input  logic [sifh_pkg::NB-1:0]    peak_bin,
    output logic                       result_valid,
    output logic [sifh_pkg::PIX_W-1:0] result_pixel,
    output logic [sifh_pkg::RES_W-1:0] result
);

    logic [sifh_pkg::PIX_W-1:0] pix_cnt;
    sifh_pkg::hist_sel_e        sel;
    logic [sifh_pkg::NB-1:0]    coarse_pk [sifh_pkg::PIXEL_NUM];

    // peaks come in pixel order, coarse pass first
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pix_cnt      <= '0;
            sel          <= sifh_pkg::COARSE;
            result_valid <= 1'b0;
        end else begin
            result_valid <= peak_valid && (sel == sifh_pkg::FINE);
            if (peak_valid) begin
                if (pix_cnt == sifh_pkg::PIXEL_NUM - 1) begin
                    pix_cnt <= '0;
                    sel     <= (sel == sifh_pkg::COARSE) ? sifh_pkg::FINE : sifh_pkg::COARSE;
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (peak_valid && sel == sifh_pkg::COARSE) begin
            coarse_pk[pix_cnt] <= peak_bin;
        end
        if (peak_valid && sel == sifh_pkg::FINE) begin
            result_pixel <= pix_cnt;
            result       <= {coarse_pk[pix_cnt], peak_bin};
        end
    end

endmodule

/* peak_tracker.sv */
`timescale 1ns/1ps

module peak_tracker (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         hit,
    input  logic [sifh_pkg::NB-1:0]      hit_bin,
    input  logic [sifh_pkg::COUNT_W-1:0] hit_count,
    input  logic                         pixel_last,
    output logic                         peak_valid,
    output logic [sifh_pkg::NB-1:0]      peak_bin
);

    logic [sifh_pkg::COUNT_W-1:0] max_count;
    logic [sifh_pkg::NB-1:0]      max_bin;
    logic                         greater;

    // strict compare keeps the first bin to reach the max
    assign greater = hit_count > max_count;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            max_count  <= '0;
            peak_valid <= 1'b0;
        end else begin
            peak_valid <= hit && pixel_last;
            if (hit) begin
                if (pixel_last) begin
                    max_count <= '0;
                end else if (greater) begin
                    max_count <= hit_count;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit && greater) begin
            max_bin <= hit_bin;
        end
        // last hit of the pixel still counts toward its peak
        if (hit && pixel_last) begin
            peak_bin <= greater ? hit_bin : max_bin;
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (!res)
        hit |-> hit_count <= sifh_pkg::DATA_NUM);

endmodule

/* sifh_fsm.sv */
`timescale 1ns/1ps

module sifh_fsm (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       wr_en,
    output logic                       ready,
    output logic                       acc,
    output logic [sifh_pkg::PIX_W-1:0] pixel,
    output logic                       pixel_last,
    output logic                       clear_start,
    input  logic                       clear_done
);

    sifh_pkg::fsm_state_e         state;
    sifh_pkg::hist_sel_e          sel;
    logic [sifh_pkg::COUNT_W-1:0] evt_cnt;
    logic [1:0]                   wait_cnt;
    logic                         evt_last;
    logic                         pix_end;

    // events only accepted while histogramming
    assign ready    = (state == sifh_pkg::HIS_PEAK);
    assign acc      = wr_en && ready;
    assign evt_last = (evt_cnt == sifh_pkg::DATA_NUM - 1);
    assign pix_end  = (pixel == sifh_pkg::PIXEL_NUM - 1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= sifh_pkg::CLEAR;
            sel         <= sifh_pkg::COARSE;
            evt_cnt     <= '0;
            pixel       <= '0;
            wait_cnt    <= '0;
            pixel_last  <= 1'b0;
            // sweep kicks off right after reset
            clear_start <= 1'b1;
        end else begin
            clear_start <= 1'b0;
            // same edge as the builder registers the hit
            pixel_last  <= acc && evt_last;
            case (state)
                sifh_pkg::CLEAR: begin
                    if (clear_done) begin
                        state <= sifh_pkg::HIS_PEAK;
                    end
                end
                sifh_pkg::HIS_PEAK: begin
                    if (acc) begin
                        if (!evt_last) begin
                            evt_cnt <= evt_cnt + 1'b1;
                        end else begin
                            evt_cnt <= '0;
                            if (!pix_end) begin
                                pixel <= pixel + 1'b1;
                            end else begin
                                pixel <= '0;
                                if (sel == sifh_pkg::COARSE) begin
                                    sel <= sifh_pkg::FINE;
                                end else begin
                                    // frame done, let the pipeline drain
                                    sel      <= sifh_pkg::COARSE;
                                    state    <= sifh_pkg::ALGEBRAIC_CAL;
                                    wait_cnt <= '0;
                                end
                            end
                        end
                    end
                end
                sifh_pkg::ALGEBRAIC_CAL: begin
                    if (wait_cnt == sifh_pkg::PIPE_DEPTH - 1) begin
                        state       <= sifh_pkg::CLEAR;
                        clear_start <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= sifh_pkg::CLEAR;
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!res)
        !$isunknown(state) &&
        (state inside {sifh_pkg::CLEAR, sifh_pkg::HIS_PEAK, sifh_pkg::ALGEBRAIC_CAL}));

endmodule

/* sifh_pkg.sv */
package sifh_pkg;

    // bin address width, 16 bins per histogram
    localparam int NB = 4;
    localparam int BIN_NUM = 2 ** NB;

    // events per pixel in each pass
    localparam int DATA_NUM = 8;

    // pixel array
    localparam int PIXEL_NUM = 2;
    localparam int PIX_W = 1;

    // bin count must hold DATA_NUM
    localparam int COUNT_W = 4;

    // one histogram region per pixel
    localparam int MEM_DEPTH = BIN_NUM * PIXEL_NUM;

    // memory index is {pixel, bin}
    localparam int ADDR_W = PIX_W + NB;

    // joined result: coarse peak above fine peak
    localparam int RES_W = 2 * NB;

    // hit, peak, result register stages after an accepted event
    localparam int PIPE_DEPTH = 3;

    // frame sequencer states
    typedef enum logic [1:0] {
        CLEAR         = 2'd0,
        HIS_PEAK      = 2'd1,
        ALGEBRAIC_CAL = 2'd2
    } fsm_state_e;

    // acquisition pass
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } hist_sel_e;

endpackage

/* sifh_top.sv */
`timescale 1ns/1ps

module sifh_top (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       wr_en,
    input  logic [sifh_pkg::NB-1:0]    addr,
    output logic                       ready,
    output logic                       result_valid,
    output logic [sifh_pkg::PIX_W-1:0] result_pixel,
    output logic [sifh_pkg::RES_W-1:0] result
);

    logic                         acc;
    logic [sifh_pkg::PIX_W-1:0]   pixel;
    logic                         pixel_last;
    logic                         clear_start;
    logic                         clear_done;
    logic                         hit;
    logic [sifh_pkg::NB-1:0]      hit_bin;
    logic [sifh_pkg::COUNT_W-1:0] hit_count;
    logic                         peak_valid;
    logic [sifh_pkg::NB-1:0]      peak_bin;

    sifh_fsm i_fsm (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .ready       (ready),
        .acc         (acc),
        .pixel       (pixel),
        .pixel_last  (pixel_last),
        .clear_start (clear_start),
        .clear_done  (clear_done)
    );

    hist_builder i_hist (
        .clk         (clk),
        .res         (res),
        .acc         (acc),
        .addr        (addr),
        .pixel       (pixel),
        .clear_start (clear_start),
        .clear_done  (clear_done),
        .hit         (hit),
        .hit_bin     (hit_bin),
        .hit_count   (hit_count)
    );

    peak_tracker i_peak (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .hit_bin    (hit_bin),
        .hit_count  (hit_count),
        .pixel_last (pixel_last),
        .peak_valid (peak_valid),
        .peak_bin   (peak_bin)
    );

    peak_combiner i_comb (
        .clk          (clk),
        .res          (res),
        .peak_valid   (peak_valid),
        .peak_bin     (peak_bin),
        .result_valid (result_valid),
        .result_pixel (result_pixel),
        .result       (result)
    );

endmodule

/* sifh_vectors.txt */
// one 5-digit hex word per record: kind, test tag, field a, field b (two digits)
// kind 1 event (a addr), 2 refused strobe (a addr, b idle cycles before it)
// kind 3 expected result (tag test, a pixel, b result), 4 gap mode (a 1 back-to-back)
40000
// frame one coarse pass, pixel 0 then pixel 1
10500 10500 10300 10500 10200 10500 10100 10000
10a00 10a00 10a00 10c00 10c00 10200 10a00 10700
// fine pass, pixel 0 ties bins 9 and 3 at three and bin 3 gets there first
10900 10300 10300 10500 10900 10300 10900 10000
10100 10600 10600 10600 10b00 10600 10600 10f00
33053
321a6
// strobes late in the sweep, all aimed at bin 4
20414 20400 20400 20400 20400 20400
// frame two with back-to-back events
40100
10400 10400 10400 10800 10800 10800 10800 10100
10a00 10b00 10b00 10c00 10c00 10c00 10b00 10d00
10000 10000 10f00 10f00 10f00 10200 10000 10f00
10700 10700 10700 10700 10700 10700 10700 10700
3508f
351c7

/* tb_sifh.sv */
`timescale 1ns/1ps

module tb_sifh;

    localparam int PERIOD = 4;
    localparam int LATENCY = 3;
    localparam int VEC_MAX = 128;
    localparam int FRAME_EVENTS = 2 * sifh_pkg::PIXEL_NUM * sifh_pkg::DATA_NUM;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                       clk;
    logic                       res;
    logic                       wr_en;
    logic [sifh_pkg::NB-1:0]    addr;
    logic                       ready;
    logic                       result_valid;
    logic [sifh_pkg::PIX_W-1:0] result_pixel;
    logic [sifh_pkg::RES_W-1:0] result;

    // record word is kind, test tag, field a, field b
    logic [19:0] vec [VEC_MAX];
    logic [19:0] exp_q [$];
    int          due_q [$];
    int          errs [1:5];
    int          remaining [1:5];
    bit          reported [1:5];
    logic [31:0] lfsr;
    int          cyc;
    int          ev_cnt;
    bit          burst;
    int          limit_ns;

    sifh_top i_dut (
        .clk          (clk),
        .res          (res),
        .wr_en        (wr_en),
        .addr         (addr),
        .ready        (ready),
        .result_valid (result_valid),
        .result_pixel (result_pixel),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout: the run did not end within %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    function automatic string test_title(input int t);
        case (t)
            1: return "reset and clear sweep";
            2: return "frame one peaks";
            3: return "tie goes to the first bin";
            4: return "result latency";
            default: return "frame two after refused strobes";
        endcase
    endfunction

    task automatic draw_bits(input int n, output int bits);
        int i;
        bits = 0;
        for (i = 0; i < n; i++) begin
            bits = (bits << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_test(input int t);
        if (errs[t] == 0) begin
            $display("test %0d %s: ok", t, test_title(t));
        end else begin
            $display("test %0d %s: failed with %0d errors", t, test_title(t), errs[t]);
        end
        reported[t] = 1'b1;
    endtask

    task automatic check_result();
        logic [19:0] rec;
        int t;
        int due;
        assert (exp_q.size() > 0) else begin
            $display("result_valid came with no expected result left");
            errs[4]++;
        end
        if (exp_q.size() > 0) begin
            rec = exp_q.pop_front();
            t = rec[15:12];
            assert (result_pixel == rec[11:8]) else begin
                $display("Error: result_pixel expected 0x%0h got 0x%0h", rec[11:8], result_pixel);
                errs[t]++;
            end
            assert (result == rec[7:0]) else begin
                $display("Error: result expected 0x%0h got 0x%0h", rec[7:0], result);
                errs[t]++;
            end
            due = -1;
            if (due_q.size() > 0) begin
                due = due_q.pop_front();
            end
            assert (cyc == due) else begin
                $display("Error: result_valid cycle expected 0x%0h got 0x%0h", due, cyc);
                errs[4]++;
            end
            remaining[t]--;
            if (remaining[t] == 0) begin
                report_test(t);
            end
        end
    endtask

    // outputs are sampled on the falling edge before inputs change
    task automatic tick();
        @(negedge clk);
        cyc++;
        if (res && result_valid) begin
            check_result();
        end
    endtask

    task automatic drive_event(input logic [sifh_pkg::NB-1:0] a);
        int gap;
        int k;
        gap = 0;
        if (!burst) begin
            draw_bits(2, gap);
        end
        repeat (gap) begin
            tick();
            wr_en = 1'b0;
        end
        tick();
        while (!ready) begin
            wr_en = 1'b0;
            tick();
        end
        wr_en = 1'b1;
        addr  = a;
        // last event of a pixel in the fine half of the frame
        k = ev_cnt % FRAME_EVENTS;
        if (k >= FRAME_EVENTS / 2 && k % sifh_pkg::DATA_NUM == sifh_pkg::DATA_NUM - 1) begin
            due_q.push_back(cyc + LATENCY);
        end
        ev_cnt++;
    endtask

    task automatic drive_junk(input logic [sifh_pkg::NB-1:0] a, input int delay);
        repeat (delay) begin
            tick();
            wr_en = 1'b0;
        end
        tick();
        assert (!ready) else begin
            $display("A refused strobe found ready high and would have been counted");
            errs[5]++;
        end
        wr_en = 1'b1;
        addr  = a;
    endtask

    initial begin : stimulus
        int i;
        int t;
        int n;
        int rise;
        int total;
        int failed;
        logic [19:0] rec;
        res    = 1'b0;
        wr_en  = 1'b0;
        addr   = '0;
        cyc    = 0;
        ev_cnt = 0;
        burst  = 1'b0;
        lfsr   = 32'he6dd;
        for (i = 1; i <= 5; i++) begin
            errs[i]      = 0;
            remaining[i] = 0;
            reported[i]  = 1'b0;
        end
        for (i = 0; i < VEC_MAX; i++) begin
            vec[i] = '0;
        end
        $readmemh("sifh_vectors.txt", vec);

        // queue the expected results and count events for the watchdog
        n = 0;
        for (i = 0; i < VEC_MAX; i++) begin
            if (vec[i][19:16] == 4'h3) begin
                exp_q.push_back(vec[i]);
                remaining[vec[i][15:12]]++;
            end else if (vec[i][19:16] == 4'h1) begin
                n++;
            end
        end
        limit_ns = (n * 4 + 3 * (sifh_pkg::MEM_DEPTH + 10) + 100) * PERIOD;

        repeat (10) tick();
        assert (!ready) else begin
            $display("ready was high while reset was held");
            errs[1]++;
        end
        res  = 1'b1;
        n    = 0;
        rise = 0;
        while (rise == 0 && n < 2 * sifh_pkg::MEM_DEPTH) begin
            tick();
            n++;
            assert (!result_valid) else begin
                $display("Error: result_valid expected 0x0 got 0x%0h", result_valid);
                errs[1]++;
            end
            if (ready) begin
                rise = n;
            end
        end
        assert (rise == sifh_pkg::MEM_DEPTH + 1) else begin
            $display("Error: ready rise cycle expected 0x%0h got 0x%0h",
                     sifh_pkg::MEM_DEPTH + 1, rise);
            errs[1]++;
        end
        report_test(1);

        i = 0;
        while (i < VEC_MAX && vec[i][19:16] != 4'h0) begin
            rec = vec[i];
            case (rec[19:16])
                4'h1: drive_event(rec[11:8]);
                4'h2: drive_junk(rec[11:8], rec[7:0]);
                4'h4: burst = rec[8];
                default: ;
            endcase
            i++;
        end

        tick();
        wr_en = 1'b0;
        n = 0;
        while (exp_q.size() > 0 && n < 8 * LATENCY) begin
            tick();
            n++;
        end
        // stray results would show up here
        repeat (8) tick();

        total  = 0;
        failed = 0;
        for (t = 1; t <= 5; t++) begin
            assert (remaining[t] == 0) else begin
                $display("Test %0d: %0d expected results never came out", t, remaining[t]);
                errs[t]++;
            end
            if (!reported[t]) begin
                report_test(t);
            end
            total += errs[t];
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("summary: 5 tests, %0d passed, %0d failed, %0d errors", 5 - failed, failed, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
